// ==== ff_stuffer_top.f ====
+incdir+source
source/jpeg_byte_pkg.sv
source/stuff_stream_pkg.sv
source/byte_stuffer.sv
source/group_fifo.sv
source/word_packer.sv
source/ff_stuffer_top.sv
verification/tb_clock_gen.sv
verification/tb_ff_stuffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the byte stuffer testbench with Verilator.
# Exits non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ff_stuffer \
    -Mdir "$OBJ" \
    -f ff_stuffer_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_ff_stuffer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== source/byte_stuffer.sv ====
// Marker byte stuffer
// Four stage pipeline, inserts a 0x00 after every 0xFF byte of an
// input word and hands out a left-justified group of 4 to 8 bytes

`timescale 1ns/1ps
`include "ff_stuff_consts.svh"

module byte_stuffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  jpeg_byte_pkg::word_t             in_word,
    output logic                             grp_valid,
    output stuff_stream_pkg::stuffed_group_t grp
);

    import jpeg_byte_pkg::*;

    // Zero lanes below the incoming word
    localparam int PAD_W = (`FF_GROUP_BYTES - `FF_WORD_BYTES) * `FF_BYTE_W;

    logic [`FF_WORD_BYTES-1:0] in_flags;    // Bit i marks lane i (lane 0 on top)
    logic                      s1_valid;
    logic                      s2_valid;
    logic                      s3_valid;
    group_data_t               s1_data;
    group_data_t               s2_data;
    group_data_t               s3_data;
    group_data_t               s4_data;     // Lanes 1 and 0 resolved
    logic [`FF_WORD_BYTES-1:0] s1_flags;
    logic [`FF_WORD_BYTES-1:0] s2_flags;
    logic [`FF_WORD_BYTES-1:0] s3_flags;

    function automatic logic is_marker(input byte_t b);
        return b == `FF_MARKER_BYTE;
    endfunction

    // Open a stuff byte right after lane "lane"
    // Lanes above stay put, everything below moves down one lane
    function automatic group_data_t stuff_lane(input group_data_t g, input int lane);
        group_data_t shifted;
        group_data_t r;
        shifted = g >> `FF_BYTE_W;
        for (int i = 0; i < `FF_GROUP_BYTES; i++) begin
            int base;
            base = (`FF_GROUP_BYTES - 1 - i) * `FF_BYTE_W;
            if (i <= lane)
                r[base +: `FF_BYTE_W] = g[base +: `FF_BYTE_W];
            else if (i == lane + 1)
                r[base +: `FF_BYTE_W] = `FF_STUFF_BYTE;
            else
                r[base +: `FF_BYTE_W] = shifted[base +: `FF_BYTE_W];
        end
        return r;
    endfunction

    // Marker detect on the raw word
    always_comb begin
        for (int i = 0; i < `FF_WORD_BYTES; i++)
            in_flags[i] = is_marker(in_word[(`FF_WORD_BYTES-1-i)*`FF_BYTE_W +: `FF_BYTE_W]);
    end

    // Last two lanes in the final stage, lane 1 before lane 0
    always_comb begin
        s4_data = s3_data;
        if (s3_flags[1])
            s4_data = stuff_lane(s4_data, 1);
        if (s3_flags[0])
            s4_data = stuff_lane(s4_data, 0);
    end

    // ------------------------------------------------------------------------
    // Valid chain, one bit per stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            grp_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            grp_valid <= s3_valid;
        end
    end

    // ------------------------------------------------------------------------
    // Data path, lanes resolved bottom up so pending lanes never move
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_data  <= {in_word, {PAD_W{1'b0}}};   // Word into the top lanes
            s1_flags <= in_flags;
        end
        if (s1_valid) begin
            s2_data  <= s1_flags[3] ? stuff_lane(s1_data, 3) : s1_data;   // Lane 3
            s2_flags <= s1_flags;
        end
        if (s2_valid) begin
            s3_data  <= s2_flags[2] ? stuff_lane(s2_data, 2) : s2_data;   // Lane 2
            s3_flags <= s2_flags;
        end
        if (s3_valid) begin
            grp.data <= s4_data;
            grp.len  <= group_len_t'(`FF_WORD_BYTES) + group_len_t'($countones(s3_flags));
        end
    end

endmodule

// ==== source/ff_stuff_consts.svh ====
// JPEG byte stuffer constants
// Byte geometry, buffer sizes and the marker and stuff byte values
// shared by the stuffing, buffering and packing stages

`ifndef FF_STUFF_CONSTS_SVH
`define FF_STUFF_CONSTS_SVH

// ------------------------------------------------------------------------
// Stream geometry
// ------------------------------------------------------------------------
`define FF_BYTE_W       8     // Bits per byte
`define FF_WORD_BYTES   4     // Bytes per input or output word
`define FF_GROUP_BYTES  8     // Worst case, every lane a marker

// Buffering
`define FF_PACK_BYTES   12    // Packer holding buffer
`define FF_FIFO_DEPTH   8     // Default group FIFO depth, power of two

// ------------------------------------------------------------------------
// Byte values
// ------------------------------------------------------------------------
`define FF_MARKER_BYTE  8'hFF // Needs escaping in entropy data
`define FF_STUFF_BYTE   8'h00 // Inserted after each marker byte

`endif

// ==== source/ff_stuffer_top.sv ====
// JPEG entropy stream byte stuffer, top level
// Stuffs 0x00 after every 0xFF of the input words, buffers the
// grown groups and repacks them into aligned 32-bit output words

`timescale 1ns/1ps

module ff_stuffer_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,   // At most one cycle in two
    input  jpeg_byte_pkg::word_t in_word,
    output logic                 out_valid,
    output jpeg_byte_pkg::word_t out_word
);

    import stuff_stream_pkg::*;

    logic           grp_valid;   // Stuffer to FIFO
    stuffed_group_t grp;
    logic           rd_en;       // Packer to FIFO
    stuffed_group_t rd_group;
    logic           rd_valid;
    fifo_status_t   status;

    // ------------------------------------------------------------------------
    // Stuffing, buffering, packing
    // ------------------------------------------------------------------------
    byte_stuffer i_stuffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .grp_valid (grp_valid),
        .grp       (grp)
    );

    group_fifo i_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (grp_valid),   // No back-pressure toward the stuffer
        .wr_group (grp),
        .rd_en    (rd_en),
        .rd_group (rd_group),
        .rd_valid (rd_valid),
        .status   (status)
    );

    word_packer i_packer (
        .clk       (clk),
        .rst       (rst),
        .rd_group  (rd_group),
        .rd_valid  (rd_valid),
        .status    (status),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

// ==== source/group_fifo.sv ====
// Stuffed group FIFO
// Soaks up the extra bytes created by stuffing until the packer has room
// Registered read port with one cycle latency

`timescale 1ns/1ps
`include "ff_stuff_consts.svh"

module group_fifo #(
    parameter int DEPTH = `FF_FIFO_DEPTH   // Power of two
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_en,
    input  stuff_stream_pkg::stuffed_group_t wr_group,
    input  logic                             rd_en,
    output stuff_stream_pkg::stuffed_group_t rd_group,
    output logic                             rd_valid,
    output stuff_stream_pkg::fifo_status_t   status
);

    import stuff_stream_pkg::*;

    localparam int             PTR_W     = $clog2(DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(DEPTH);

    stuffed_group_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;     // Wraps naturally
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;      // Groups held, 0 to DEPTH
    logic             wr_do;

    assign status.empty = (count == '0);
    assign status.full  = (count == DEPTH_CNT);

    assign wr_do = wr_en && !status.full;    // Never clobber a held group

    // Storage and read register
    always_ff @(posedge clk) begin
        if (wr_do)
            mem[wr_ptr] <= wr_group;
        if (rd_en)
            rd_group <= mem[rd_ptr];
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;                   // Data lands one cycle after rd_en
            if (wr_do)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_do, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Idle, or write and read together
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // Input rate rule as seen four cycles after the stuffer input
    a_wr_rate: assert property (@(posedge clk) disable iff (rst) wr_en |=> !wr_en);

    a_no_wr_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !status.full);

    // Packer must only pull when it saw data
    a_no_rd_empty: assert property (@(posedge clk) disable iff (rst) rd_en |-> !status.empty);

endmodule

// ==== source/jpeg_byte_pkg.sv ====
// JPEG stream byte types
// Vector types for bytes, words and stuffed byte groups; the first
// byte of the stream always sits in the top lane

`include "ff_stuff_consts.svh"

package jpeg_byte_pkg;

    // One byte of entropy coded data
    typedef logic [`FF_BYTE_W-1:0] byte_t;

    // Input and output word, first byte in bits 31:24
    typedef logic [`FF_WORD_BYTES*`FF_BYTE_W-1:0] word_t;

    // Eight byte lanes, left-justified, unused lanes read as zero
    typedef logic [`FF_GROUP_BYTES*`FF_BYTE_W-1:0] group_data_t;

    // Valid bytes in a group, 4 when clean and up to 8
    typedef logic [$clog2(`FF_GROUP_BYTES+1)-1:0] group_len_t;

endpackage

// ==== source/stuff_stream_pkg.sv ====
// Stuffed stream interface types
// Structures carried from the stuffer through the group FIFO into
// the word packer

package stuff_stream_pkg;

    import jpeg_byte_pkg::*;

    // One stuffed input word
    typedef struct packed {
        group_data_t data;  // Left-justified bytes
        group_len_t  len;   // Byte count incl. inserted stuff bytes
    } stuffed_group_t;

    // FIFO fill flags seen by the packer
    typedef struct packed {
        logic empty;
        logic full;
    } fifo_status_t;

endpackage

// ==== source/word_packer.sv ====
// Word packer
// Collects stuffed groups behind the leftover bytes of a 12 byte
// buffer and emits aligned 32-bit words, top four bytes first

`timescale 1ns/1ps
`include "ff_stuff_consts.svh"

module word_packer (
    input  logic                             clk,
    input  logic                             rst,
    input  stuff_stream_pkg::stuffed_group_t rd_group,
    input  logic                             rd_valid,
    input  stuff_stream_pkg::fifo_status_t   status,
    output logic                             rd_en,
    output logic                             out_valid,
    output jpeg_byte_pkg::word_t             out_word
);

    import jpeg_byte_pkg::*;

    localparam int PACK_W  = `FF_PACK_BYTES * `FF_BYTE_W;     // 96
    localparam int WORD_W  = `FF_WORD_BYTES * `FF_BYTE_W;     // 32
    localparam int GROUP_W = `FF_GROUP_BYTES * `FF_BYTE_W;    // 64
    localparam int CNT_W   = $clog2(`FF_PACK_BYTES + 1);

    localparam logic [CNT_W-1:0] WORD_CNT = CNT_W'(`FF_WORD_BYTES);
    localparam logic [CNT_W-1:0] PACK_CNT = CNT_W'(`FF_PACK_BYTES);
    localparam logic [CNT_W-1:0] ROOM_CNT = CNT_W'(`FF_PACK_BYTES - `FF_GROUP_BYTES);

    logic [PACK_W-1:0] pack_buf;    // Left-justified, bytes past cnt are don't care
    logic [CNT_W-1:0]  cnt;
    logic              emit;        // Full word available this cycle
    logic [PACK_W-1:0] rem_buf;     // Buffer after this cycle's emission
    logic [CNT_W-1:0]  rem_cnt;
    logic [PACK_W-1:0] keep_mask;   // Covers the rem_cnt valid bytes
    logic [PACK_W-1:0] ins_buf;     // Arriving group placed behind them
    logic [PACK_W-1:0] buf_next;
    logic [CNT_W-1:0]  cnt_next;
    group_data_t       grp_data;

    assign grp_data = rd_group.data;

    // ------------------------------------------------------------------------
    // Next buffer state
    // ------------------------------------------------------------------------
    always_comb begin
        emit      = (cnt >= WORD_CNT);
        rem_buf   = emit ? (pack_buf << WORD_W) : pack_buf;
        rem_cnt   = emit ? (cnt - WORD_CNT) : cnt;
        keep_mask = ~({PACK_W{1'b1}} >> (int'(rem_cnt) * `FF_BYTE_W));
        ins_buf   = {grp_data, {(PACK_W - GROUP_W){1'b0}}} >> (int'(rem_cnt) * `FF_BYTE_W);
        if (rd_valid) begin
            buf_next = (rem_buf & keep_mask) | ins_buf;   // Unused group lanes are zero
            cnt_next = rem_cnt + CNT_W'(rd_group.len);
        end else begin
            buf_next = rem_buf;
            cnt_next = rem_cnt;
        end
    end

    // Pull a group only if one is waiting, none is in flight, and 8 bytes fit
    assign rd_en = !status.empty && !rd_valid && (rem_cnt <= ROOM_CNT);

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        pack_buf <= buf_next;
        if (emit)
            out_word <= pack_buf[PACK_W-1 -: WORD_W];   // Oldest four bytes
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            out_valid <= 1'b0;
        end else begin
            cnt       <= cnt_next;
            out_valid <= emit;      // One strobe per word
        end
    end

    // Read gating has to keep the buffer within bounds
    a_cnt_bound: assert property (@(posedge clk) disable iff (rst) cnt <= PACK_CNT);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free running clock, reset held high for the first few cycles and
// released on a falling edge

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,   // Full clock period
    parameter int RESET_CYCLES = 3     // Rising edges seen under reset
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    // Release away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== verification/tb_ff_stuffer.sv ====
// Byte stuffer testbench
// Drives clean, marker, all-marker and random words, keeps a reference
// byte stream with stuff bytes inserted and checks every output word

`timescale 1ns/1ps
`include "ff_stuff_consts.svh"

module tb_ff_stuffer;

    import jpeg_byte_pkg::*;

    // Rough run length: reset, quiet, clean, lanes, all-marker, random, drain
    localparam int TEST_CYCLES    = 3 + 4 + 2*16 + 2*8 + 2*8 + 3*200 + 20;
    localparam int TIMEOUT_CYCLES = ((TEST_CYCLES * 5 / 2) + 499) / 500 * 500;

    logic  clk;
    logic  rst;
    logic  in_valid;
    word_t in_word;
    logic  out_valid;
    word_t out_word;

    byte_t       ref_q[$];         // Expected output bytes, stuff bytes included
    int          ref_tag[$];       // Test that produced each byte
    string       test_names [6] = '{"reset_quiet", "clean_words", "marker_per_lane",
                                    "all_marker", "random_stream", "drain_count"};
    int          cur_test = 0;
    int          out_idx = 0;      // Next reference byte to compare
    int          out_count = 0;
    word_t       exp_word = '0;
    logic        exp_avail = 1'b0; // Four reference bytes are pending
    int          exp_test = 0;
    int          data_errors = 0;
    int          protocol_errors = 0;
    int          drain_errors = 0;
    int          cycle_cnt = 0;
    logic [15:0] lfsr_state = 16'd47;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) i_clk_gen (.clk(clk), .rst(rst));

    ff_stuffer_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    // ------------------------------------------------------------------------
    // Random bits, x^16 + x^14 + x^13 + x^11 + 1
    // ------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Lane is a marker one time in four, otherwise a random byte
    task automatic random_word(output word_t w);
        logic [31:0] pick;
        logic [31:0] val;
        w = '0;
        for (int k = 0; k < `FF_WORD_BYTES; k++) begin
            take_bits(2, pick);
            if (pick[1:0] == 2'b00)
                val = 32'(`FF_MARKER_BYTE);
            else
                take_bits(`FF_BYTE_W, val);
            w = {w[23:0], val[7:0]};
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers, called on a falling edge
    // ------------------------------------------------------------------------
    task automatic push_ref(input byte_t b);
        ref_q.push_back(b);
        ref_tag.push_back(cur_test);
        if (b == `FF_MARKER_BYTE) begin
            ref_q.push_back(`FF_STUFF_BYTE);      // Escape follows the marker
            ref_tag.push_back(cur_test);
        end
    endtask

    // One valid cycle then one idle cycle, the fastest legal rate
    task automatic send_word(input word_t w);
        byte_t b;
        in_valid = 1'b1;
        in_word  = w;
        for (int k = 0; k < `FF_WORD_BYTES; k++) begin
            b = w[(`FF_WORD_BYTES-1-k)*`FF_BYTE_W +: `FF_BYTE_W];   // Top lane first
            push_ref(b);
        end
        @(negedge clk);
        in_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Reference tracking
    // ------------------------------------------------------------------------
    // Expected word set up half a cycle ahead, stable at the rising edge
    always @(negedge clk) begin
        if (ref_q.size() >= out_idx + `FF_WORD_BYTES) begin
            exp_word  = {ref_q[out_idx], ref_q[out_idx+1], ref_q[out_idx+2], ref_q[out_idx+3]};
            exp_test  = ref_tag[out_idx];
            exp_avail = 1'b1;
        end else begin
            exp_word  = '0;
            exp_avail = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst && out_valid) begin
            out_idx   <= out_idx + `FF_WORD_BYTES;   // Consume the compared bytes
            out_count <= out_count + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
        else begin
            protocol_errors++;
            $display("out_valid was raised while reset was held");
        end

    // Covers early words after reset and any extra word at the end
    a_has_ref: assert property (@(posedge clk) disable iff (rst) out_valid |-> exp_avail)
        else begin
            protocol_errors++;
            $display("Output word came out before four stuffed bytes were sent");
        end

    a_out_data: assert property (@(posedge clk) disable iff (rst)
        out_valid && exp_avail |-> out_word == exp_word)
        else begin
            data_errors++;
            $display("ERROR %s: expected %h, actual %h", test_names[exp_test],
                     exp_word, $sampled(out_word));
        end

    // Hang guard
    always @(posedge clk) begin
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles, %0d words out",
                     TIMEOUT_CYCLES, out_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] gap;
        word_t       w;
        in_valid = 1'b0;
        in_word  = '0;
        wait (rst === 1'b0);
        @(negedge clk);

        cur_test = 0;
        idle_cycles(4);                            // Nothing in, nothing out

        cur_test = 1;
        for (int i = 0; i < 16; i++)
            send_word({byte_t'(4*i), byte_t'(4*i+1), byte_t'(4*i+2), byte_t'(4*i+3)});

        cur_test = 2;
        for (int r = 0; r < 2; r++) begin
            for (int lane = 0; lane < `FF_WORD_BYTES; lane++) begin
                w = 32'h1234_5670 + 32'(r);
                w[(`FF_WORD_BYTES-1-lane)*`FF_BYTE_W +: `FF_BYTE_W] = `FF_MARKER_BYTE;
                send_word(w);
            end
        end

        cur_test = 3;
        repeat (8) send_word({`FF_WORD_BYTES{`FF_MARKER_BYTE}});   // Doubles every byte

        cur_test = 4;
        for (int i = 0; i < 200; i++) begin
            random_word(w);
            send_word(w);
            take_bits(1, gap);
            if (gap[0])
                idle_cycles(1);
        end

        cur_test = 5;
        idle_cycles(20);
        a_drain: assert (out_count == ref_q.size() / `FF_WORD_BYTES)
            else begin
                drain_errors++;
                $display("ERROR %s: expected %0d, actual %0d", test_names[5],
                         ref_q.size() / `FF_WORD_BYTES, out_count);
            end

        $display("Done: %0d words out, errors data %0d protocol %0d drain %0d",
                 out_count, data_errors, protocol_errors, drain_errors);
        if (data_errors + protocol_errors + drain_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
